/* bench/tb_checker.sv */
`default_nettype none

module tb_checker
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  store_valid_i,
    input  word_t store_addr_i,
    input  word_t store_data_i,
    input  logic  halted_i
);

    timeunit 1ns;
    timeprecision 1ps;

    word_t exp_addr_q [$];
    word_t exp_data_q [$];
    string test_name = "";
    int    seen;
    int    test_errs;
    int    total_errs;
    int    tests_run;
    int    tests_failed;

    function automatic void begin_test(string name);
        exp_addr_q.delete();
        exp_data_q.delete();
        test_name = name;
        seen      = 0;
        test_errs = 0;
    endfunction

    function automatic void add_expected(word_t addr, word_t data);
        exp_addr_q.push_back(addr);
        exp_data_q.push_back(data);
    endfunction

    function automatic void note_error(string msg);
        $display("ERROR in %s: %s", test_name, msg);
        test_errs++;
    endfunction

    function automatic void check_halted(logic expected);
        if (halted_i !== expected) begin
            $display("FAIL %s halted_o: expected %b, actual %b",
                     test_name, expected, halted_i);
            test_errs++;
        end
    endfunction

    // stores are sampled mid cycle in commit order
    always @(negedge clk) begin
        if (store_valid_i) begin
            if (seen >= exp_addr_q.size()) begin
                note_error($sformatf("unexpected store of %h to address %h",
                                     store_data_i, store_addr_i));
            end else begin
                if (store_addr_i !== exp_addr_q[seen]) begin
                    $display("FAIL %s store %0d address: expected %h, actual %h",
                             test_name, seen, exp_addr_q[seen], store_addr_i);
                    test_errs++;
                end
                if (store_data_i !== exp_data_q[seen]) begin
                    $display("FAIL %s store %0d data: expected %h, actual %h",
                             test_name, seen, exp_data_q[seen], store_data_i);
                    test_errs++;
                end
            end
            seen++;
        end
    end

    function automatic void end_test();
        if (seen < exp_addr_q.size()) begin
            note_error($sformatf("%0d expected stores never appeared",
                                 exp_addr_q.size() - seen));
        end
        tests_run++;
        if (test_errs != 0) begin
            tests_failed++;
        end
        total_errs += test_errs;
        $display("test %-13s %0d stores seen, %0d expected, %0d errors",
                 test_name, seen, exp_addr_q.size(), test_errs);
    endfunction

    function automatic void report();
        $display("summary: %0d tests, %0d failed, %0d errors",
                 tests_run, tests_failed, total_errs);
    endfunction

endmodule

`default_nettype wire

/* bench/tb_top.sv */
`default_nettype none

module tb_top
    import mips_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    AW          = 10;
    localparam int    PROG_LEN    = 64;
    localparam int    NUM_RUNS    = 7;    // halt test runs two programs
    localparam int    DRAIN       = 20;   // idle cycles watched after halt
    localparam int    MAX_STEPS   = 400;
    localparam int    DATA_BASE   = 'h400;
    localparam int    WATCHDOG_NS = (NUM_RUNS * PROG_LEN * 10 + 200) * 8;
    localparam word_t LFSR_SEED   = 32'h5e5b_4fe3;
    localparam word_t LFSR_TAPS   = 32'h8020_0003;

    logic          clk = 1'b0;
    logic          rst;
    logic          start;
    logic          load_we;
    logic [AW-1:0] load_addr;
    word_t         load_data;
    logic          store_valid;
    word_t         store_addr;
    word_t         store_data;
    logic          halted;

    word_t prog [PROG_LEN];
    word_t ref_mem [2**AW];
    int    plen;
    int    soff;                 // next store offset from r1
    word_t lfsr_q = LFSR_SEED;

    mips_soc #(.MEM_AW(AW)) dut0 (
        .clk(clk), .rst(rst), .start_i(start),
        .load_we_i(load_we), .load_addr_i(load_addr), .load_data_i(load_data),
        .store_valid_o(store_valid), .store_addr_o(store_addr),
        .store_data_o(store_data), .halted_o(halted)
    );

    tb_checker chk0 (
        .clk(clk), .store_valid_i(store_valid),
        .store_addr_i(store_addr), .store_data_i(store_data),
        .halted_i(halted)
    );

    always #4 clk = ~clk;

    function automatic word_t lfsr_next(word_t s);
        return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
    endfunction

    function automatic word_t rand_bits(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r      = {r[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return r;
    endfunction

    function automatic word_t enc_r(logic [5:0] fn, int rs, int rt, int rd, int sh);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    function automatic word_t enc_j(int tgt);
        return {OP_J, 26'(tgt)};
    endfunction

    function automatic word_t brk_word(int a);
        return {OP_RTYPE, 20'(a), FUNCT_BREAK};   // code field carries the address
    endfunction

    function automatic void emit(word_t w);
        prog[plen] = w;
        plen++;
    endfunction

    function automatic void start_prog();
        for (int i = 0; i < PROG_LEN; i++) begin
            prog[i] = brk_word(i);
        end
        plen = 0;
        soff = 0;
        emit(enc_i(OP_ADDIU, 0, 1, DATA_BASE));   // r1 = data base
    endfunction

    function automatic void set_reg(int r, word_t v);
        emit(enc_i(OP_LUI, 0, r, int'(v >> 16)));
        emit(enc_i(OP_ORI, r, r, int'(v & 32'hffff)));
    endfunction

    function automatic void store_reg(int r);
        emit(enc_i(OP_SW, 1, r, soff));
        soff += 4;
    endfunction

    // branch over one marker store and then store a value
    function automatic void branch_case(logic [5:0] op, int rs, int rt, int val);
        emit(enc_i(op, rs, rt, 1));
        store_reg(5);
        store_reg(val);
    endfunction

    function automatic void build_alu_reg();
        logic [5:0] functs [11] = '{FUNCT_ADDU, FUNCT_SUBU, FUNCT_AND, FUNCT_OR,
                                    FUNCT_XOR, FUNCT_NOR, FUNCT_SLT, FUNCT_SLTU,
                                    FUNCT_SLL, FUNCT_SRL, FUNCT_SRA};
        int rs;
        int rt;
        int sh;
        start_prog();
        set_reg(2, rand_bits(32) | 32'h8000_0000);   // negative
        set_reg(3, rand_bits(32) & 32'h7fff_ffff);
        set_reg(4, rand_bits(32));
        set_reg(5, rand_bits(32));
        for (int k = 0; k < 11; k++) begin
            rs = int'(rand_bits(2)) + 2;
            rt = int'(rand_bits(2)) + 2;
            sh = int'(rand_bits(5));
            emit(enc_r(functs[k], rs, rt, 10, sh));
            store_reg(10);
        end
        emit(enc_r(FUNCT_SLT, 2, 3, 11, 0));
        store_reg(11);
        emit(enc_r(FUNCT_SLTU, 2, 3, 11, 0));
        store_reg(11);
        emit(enc_r(FUNCT_SLT, 3, 2, 11, 0));
        store_reg(11);
        emit(enc_r(FUNCT_SLTU, 3, 2, 11, 0));
        store_reg(11);
        for (int k = 8; k < 11; k++) begin
            sh = int'(rand_bits(5));
            emit(enc_r(functs[k], 0, 2, 12, sh));   // shifts of a negative word
            store_reg(12);
        end
        emit(brk_word(plen));
    endfunction

    function automatic void build_alu_imm();
        logic [5:0] ops [7] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI,
                                OP_LUI};
        int imm;
        int rs;
        start_prog();
        set_reg(2, rand_bits(32) | 32'h8000_0000);
        set_reg(3, rand_bits(32) & 32'h7fff_ffff);
        for (int k = 0; k < 7; k++) begin
            for (int neg = 0; neg < 2; neg++) begin
                imm = int'(rand_bits(15));
                if (neg != 0) begin
                    imm += 'h8000;
                end
                rs = int'(rand_bits(1)) + 2;
                emit(enc_i(ops[k], rs, 10, imm));
                store_reg(10);
            end
        end
        emit(brk_word(plen));
    endfunction

    function automatic void build_load_store();
        int off;
        start_prog();
        for (int k = 0; k < 4; k++) begin
            set_reg(2 + k, rand_bits(32));
        end
        for (int k = 0; k < 4; k++) begin
            off = 'h100 + k * 'h10 + int'(rand_bits(2)) * 4;
            emit(enc_i(OP_SW, 1, 2 + k, off));
            emit(enc_i(OP_LW, 1, 6 + k, off));   // read straight back
        end
        for (int k = 0; k < 4; k++) begin
            store_reg(6 + k);
        end
        emit(enc_i(OP_ADDIU, 1, 12, 'h300));
        emit(enc_i(OP_SW, 12, 2, -8));
        emit(enc_i(OP_LW, 12, 13, -8));
        store_reg(13);
        emit(brk_word(plen));
    endfunction

    function automatic void build_branch();
        start_prog();
        set_reg(2, rand_bits(32) | 32'h8000_0000);
        set_reg(3, rand_bits(32) & 32'h7fff_ffff);   // never equal to r2
        emit(enc_i(OP_ADDIU, 0, 5, 'h0bad));          // marker value
        branch_case(OP_BEQ, 2, 2, 2);
        branch_case(OP_BEQ, 2, 3, 3);
        branch_case(OP_BNE, 2, 3, 2);
        branch_case(OP_BNE, 3, 3, 3);
        emit(enc_j(plen + 2));
        store_reg(5);
        store_reg(2);
        emit(enc_i(OP_ADDIU, 0, 6, 3));
        emit(enc_i(OP_ADDIU, 1, 7, 'h200));
        emit(enc_i(OP_SW, 7, 6, 0));   // loop top
        emit(enc_i(OP_ADDIU, 7, 7, 4));
        emit(enc_i(OP_ADDIU, 6, 6, -1));
        emit(enc_i(OP_BNE, 6, 0, -4));
        store_reg(6);
        emit(brk_word(plen));
    endfunction

    function automatic void build_r0();
        start_prog();
        emit(enc_i(OP_ADDIU, 0, 0, 'h1234));
        store_reg(0);
        emit(enc_i(OP_LUI, 0, 0, int'(rand_bits(16))));
        emit(enc_i(OP_ORI, 0, 0, int'(rand_bits(16))));
        store_reg(0);
        set_reg(2, rand_bits(32) | 32'h1);
        emit(enc_r(FUNCT_ADDU, 2, 2, 0, 0));
        store_reg(0);
        store_reg(2);
        emit(enc_i(OP_LW, 1, 0, soff - 4));   // non-zero word
        store_reg(0);
        emit(brk_word(plen));
    endfunction

    function automatic void build_halt();
        start_prog();
        set_reg(2, rand_bits(32));
        store_reg(2);
        emit(brk_word(plen));
        store_reg(2);   // past the break
        emit(enc_i(OP_ADDIU, 0, 3, 'h77));
        store_reg(3);
    endfunction

    // executes the loaded program and queues the stores it should commit
    function automatic void ref_run();
        word_t      regs [32];
        word_t      pc;
        word_t      nxt;
        word_t      inst;
        word_t      a;
        word_t      b;
        word_t      y;
        word_t      imm_s;
        word_t      addr;
        logic [5:0] op;
        reg_idx_t   dst;
        logic       wr;
        logic       done;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        pc   = '0;
        done = 1'b0;
        for (int step = 0; step < MAX_STEPS && !done; step++) begin
            inst  = ref_mem[pc[AW+1:2]];
            op    = inst[31:26];
            a     = regs[inst[25:21]];
            b     = regs[inst[20:16]];
            imm_s = {{16{inst[15]}}, inst[15:0]};
            addr  = a + imm_s;
            nxt   = pc + 32'd4;
            dst   = (op == OP_RTYPE) ? inst[15:11] : inst[20:16];
            wr    = 1'b1;
            y     = '0;
            case (op)
                OP_RTYPE: begin
                    case (inst[5:0])
                        FUNCT_ADDU: y = a + b;
                        FUNCT_SUBU: y = a - b;
                        FUNCT_AND:  y = a & b;
                        FUNCT_OR:   y = a | b;
                        FUNCT_XOR:  y = a ^ b;
                        FUNCT_NOR:  y = ~(a | b);
                        FUNCT_SLT:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FUNCT_SLTU: y = (a < b) ? 32'd1 : 32'd0;
                        FUNCT_SLL:  y = b << inst[10:6];
                        FUNCT_SRL:  y = b >> inst[10:6];
                        FUNCT_SRA:  y = $signed(b) >>> inst[10:6];
                        FUNCT_BREAK: begin
                            wr   = 1'b0;
                            done = 1'b1;
                        end
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDIU: y = a + imm_s;
                OP_SLTI:  y = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
                OP_SLTIU: y = (a < imm_s) ? 32'd1 : 32'd0;
                OP_ANDI:  y = a & {16'h0000, inst[15:0]};
                OP_ORI:   y = a | {16'h0000, inst[15:0]};
                OP_XORI:  y = a ^ {16'h0000, inst[15:0]};
                OP_LUI:   y = {inst[15:0], 16'h0000};
                OP_LW:    y = ref_mem[addr[AW+1:2]];
                OP_SW: begin
                    wr = 1'b0;
                    ref_mem[addr[AW+1:2]] = b;
                    chk0.add_expected(addr, b);
                end
                OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b) nxt = nxt + (imm_s << 2);
                end
                OP_BNE: begin
                    wr = 1'b0;
                    if (a != b) nxt = nxt + (imm_s << 2);
                end
                OP_J: begin
                    wr  = 1'b0;
                    nxt = {pc[31:28], inst[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) begin
                regs[dst] = y;
            end
            pc = nxt;
        end
        if (!done) begin
            chk0.note_error("reference model never reached a break");
        end
    endfunction

    task automatic run_program();
        rst <= 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        chk0.check_halted(1'b0);
        for (int i = 0; i < PROG_LEN; i++) begin
            load_we   <= 1'b1;
            load_addr <= i[AW-1:0];
            load_data <= prog[i];
            ref_mem[i] = prog[i];
            @(posedge clk);
        end
        load_we <= 1'b0;
        ref_run();
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (!halted) @(posedge clk);
        repeat (DRAIN) @(posedge clk);   // late stores would show here
        chk0.check_halted(1'b1);
    endtask

    initial begin
        rst       <= 1'b1;
        start     <= 1'b0;
        load_we   <= 1'b0;
        load_addr <= '0;
        load_data <= '0;
        chk0.begin_test("alu_reg");
        build_alu_reg();
        run_program();
        chk0.end_test();
        chk0.begin_test("alu_imm");
        build_alu_imm();
        run_program();
        chk0.end_test();
        chk0.begin_test("load_store");
        build_load_store();
        run_program();
        chk0.end_test();
        chk0.begin_test("branch_jump");
        build_branch();
        run_program();
        chk0.end_test();
        chk0.begin_test("r0_write");
        build_r0();
        run_program();
        chk0.end_test();
        chk0.begin_test("halt_restart");
        build_halt();
        run_program();
        build_alu_reg();   // second program after reset
        run_program();
        chk0.end_test();
        chk0.report();
        if (chk0.total_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT never finished", WATCHDOG_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/alu.sv */
`default_nettype none

module alu
    import mips_pkg::*;
(
    input  alu_op_e    op_i,
    input  word_t      a_i,
    input  word_t      b_i,
    input  logic [4:0] shamt_i,
    output word_t      y_o
);

    always_comb begin
        case (op_i)
            ALU_ADD:  y_o = a_i + b_i;   // no overflow trap
            ALU_SUB:  y_o = a_i - b_i;
            ALU_AND:  y_o = a_i & b_i;
            ALU_OR:   y_o = a_i | b_i;
            ALU_XOR:  y_o = a_i ^ b_i;
            ALU_NOR:  y_o = ~(a_i | b_i);
            ALU_SLT:  y_o = {31'b0, $signed(a_i) < $signed(b_i)};
            ALU_SLTU: y_o = {31'b0, a_i < b_i};
            ALU_SLL:  y_o = a_i << shamt_i;
            ALU_SRL:  y_o = a_i >> shamt_i;
            ALU_SRA:  y_o = word_t'($signed(a_i) >>> shamt_i);
            ALU_LUI:  y_o = {b_i[15:0], 16'h0000};
            ALU_EQ:   y_o = {31'b0, a_i == b_i};   // branch compares
            ALU_NE:   y_o = {31'b0, a_i != b_i};
            default:  y_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`default_nettype none

module inst_decoder
    import mips_pkg::*;
(
    input  word_t    inst_i,
    output reg_idx_t rs_o,
    output reg_idx_t rt_o,
    output reg_idx_t dst_o,
    output word_t    imm_o,
    output logic [4:0] shamt_o,
    output alu_op_e  alu_op_o,
    output logic     b_imm_o,
    output logic     a_shamt_o,
    output logic     reg_we_o,
    output logic     is_load_o,
    output logic     is_store_o,
    output logic     is_branch_o,
    output logic     is_jump_o,
    output logic     is_break_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       zext;

    assign opcode  = inst_i[31:26];
    assign funct   = inst_i[5:0];
    assign rs_o    = inst_i[25:21];
    assign rt_o    = inst_i[20:16];
    assign shamt_o = inst_i[10:6];
    assign dst_o   = (opcode == OP_RTYPE) ? inst_i[15:11] : inst_i[20:16];   // rd or rt
    assign imm_o   = zext ? {16'h0000, inst_i[15:0]} : {{16{inst_i[15]}}, inst_i[15:0]};

    always_comb begin
        alu_op_o    = ALU_ADD;   // anything unknown falls through as a no-op
        b_imm_o     = 1'b0;
        a_shamt_o   = 1'b0;
        reg_we_o    = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        is_jump_o   = 1'b0;
        is_break_o  = 1'b0;
        zext        = 1'b0;
        case (opcode)
            OP_RTYPE: begin
                reg_we_o = 1'b1;
                case (funct)
                    FUNCT_ADDU: alu_op_o = ALU_ADD;
                    FUNCT_SUBU: alu_op_o = ALU_SUB;
                    FUNCT_AND:  alu_op_o = ALU_AND;
                    FUNCT_OR:   alu_op_o = ALU_OR;
                    FUNCT_XOR:  alu_op_o = ALU_XOR;
                    FUNCT_NOR:  alu_op_o = ALU_NOR;
                    FUNCT_SLT:  alu_op_o = ALU_SLT;
                    FUNCT_SLTU: alu_op_o = ALU_SLTU;
                    FUNCT_SLL: begin
                        alu_op_o  = ALU_SLL;
                        a_shamt_o = 1'b1;   // shift rt, not rs
                    end
                    FUNCT_SRL: begin
                        alu_op_o  = ALU_SRL;
                        a_shamt_o = 1'b1;
                    end
                    FUNCT_SRA: begin
                        alu_op_o  = ALU_SRA;
                        a_shamt_o = 1'b1;
                    end
                    FUNCT_BREAK: begin
                        reg_we_o   = 1'b0;
                        is_break_o = 1'b1;
                    end
                    default: reg_we_o = 1'b0;
                endcase
            end
            OP_J:   is_jump_o = 1'b1;
            OP_BEQ: begin
                alu_op_o    = ALU_EQ;
                is_branch_o = 1'b1;
            end
            OP_BNE: begin
                alu_op_o    = ALU_NE;
                is_branch_o = 1'b1;
            end
            OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                b_imm_o  = 1'b1;
                reg_we_o = 1'b1;
                zext     = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
                case (opcode)
                    OP_SLTI:  alu_op_o = ALU_SLT;
                    OP_SLTIU: alu_op_o = ALU_SLTU;
                    OP_ANDI:  alu_op_o = ALU_AND;
                    OP_ORI:   alu_op_o = ALU_OR;
                    OP_XORI:  alu_op_o = ALU_XOR;
                    OP_LUI:   alu_op_o = ALU_LUI;
                    default:  alu_op_o = ALU_ADD;
                endcase
            end
            OP_LW: begin
                b_imm_o   = 1'b1;
                reg_we_o  = 1'b1;
                is_load_o = 1'b1;
            end
            OP_SW: begin
                b_imm_o    = 1'b1;
                is_store_o = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mem_arbiter.sv */
`default_nettype none

module mem_arbiter
    import mips_pkg::*;
#(
    parameter int MEM_AW = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_we_i,
    input  logic [MEM_AW-1:0] load_addr_i,
    input  word_t             load_data_i,
    input  logic              fetch_req_i,
    input  word_t             fetch_addr_i,
    input  logic              dmem_req_i,
    input  logic              dmem_we_i,
    input  word_t             dmem_addr_i,
    input  word_t             dmem_wdata_i,
    output logic              fetch_gnt_o,
    output logic              dmem_gnt_o,
    output logic              fetch_rvalid_o,
    output logic              dmem_rvalid_o,
    output logic              mem_en_o,
    output logic              mem_we_o,
    output logic [MEM_AW-1:0] mem_addr_o,
    output word_t             mem_wdata_o
);

    // loader > data > fetch
    assign dmem_gnt_o  = dmem_req_i && !load_we_i;
    assign fetch_gnt_o = fetch_req_i && !load_we_i && !dmem_req_i;

    assign mem_en_o    = load_we_i || dmem_gnt_o || fetch_gnt_o;
    assign mem_we_o    = load_we_i || (dmem_gnt_o && dmem_we_i);
    assign mem_addr_o  = load_we_i  ? load_addr_i :
                         dmem_req_i ? dmem_addr_i[MEM_AW+1:2] :
                                      fetch_addr_i[MEM_AW+1:2];   // byte to word index
    assign mem_wdata_o = load_we_i ? load_data_i : dmem_wdata_i;

    // owner of the read data coming back next cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_rvalid_o <= 1'b0;
            dmem_rvalid_o  <= 1'b0;
        end else begin
            fetch_rvalid_o <= fetch_gnt_o;
            dmem_rvalid_o  <= dmem_gnt_o && !dmem_we_i;
        end
    end

    // a request that loses arbitration is held with stable fields
    a_fetch_hold: assert property (@(posedge clk) disable iff (rst)
        (fetch_req_i && !fetch_gnt_o) |=> fetch_req_i && $stable(fetch_addr_i));

    a_dmem_hold: assert property (@(posedge clk) disable iff (rst)
        (dmem_req_i && !dmem_gnt_o) |=>
            dmem_req_i && $stable({dmem_we_i, dmem_addr_i, dmem_wdata_i}));

endmodule

`default_nettype wire

/* rtl/mips_core.sv */
`default_nettype none

module mips_core
    import mips_pkg::*;
#(
    parameter int MEM_AW = 10
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  start_i,
    output logic  fetch_req_o,
    output word_t fetch_addr_o,
    input  logic  fetch_gnt_i,
    input  logic  fetch_rvalid_i,
    output logic  dmem_req_o,
    output logic  dmem_we_o,
    output word_t dmem_addr_o,
    output word_t dmem_wdata_o,
    input  logic  dmem_gnt_i,
    input  logic  dmem_rvalid_i,
    input  word_t rdata_i,
    output logic  store_valid_o,
    output word_t store_addr_o,
    output word_t store_data_o,
    output logic  halted_o
);

    core_state_e state_q;
    word_t       pc_q;
    word_t       ir_q;
    logic        req_sent_q;   // granted, waiting for rvalid
    word_t       dmem_addr_q;
    word_t       dmem_wdata_q;

    reg_idx_t    rs, rt, dst;
    word_t       imm;
    logic [4:0]  shamt;
    alu_op_e     alu_op;
    logic        b_imm, a_shamt, reg_we;
    logic        is_load, is_store, is_branch, is_jump, is_break;

    word_t       rdata_a, rdata_b, alu_a, alu_b, alu_y;
    word_t       pc_plus4, pc_next;
    logic        rf_we;
    word_t       rf_wdata;

    inst_decoder u_dec (
        .inst_i(ir_q), .rs_o(rs), .rt_o(rt), .dst_o(dst), .imm_o(imm),
        .shamt_o(shamt), .alu_op_o(alu_op), .b_imm_o(b_imm), .a_shamt_o(a_shamt),
        .reg_we_o(reg_we), .is_load_o(is_load), .is_store_o(is_store),
        .is_branch_o(is_branch), .is_jump_o(is_jump), .is_break_o(is_break)
    );

    assign alu_a = a_shamt ? rdata_b : rdata_a;
    assign alu_b = b_imm ? imm : rdata_b;

    alu u_alu (.op_i(alu_op), .a_i(alu_a), .b_i(alu_b), .shamt_i(shamt), .y_o(alu_y));

    // ALU results in exec, load data when it returns
    assign rf_we    = (state_q == ST_EXEC && reg_we && !is_load) ||
                      (state_q == ST_MEM && dmem_rvalid_i);
    assign rf_wdata = (state_q == ST_MEM) ? rdata_i : alu_y;

    reg_file u_rf (
        .clk(clk), .rst(rst), .ra_i(rs), .rb_i(rt), .rdata_a_o(rdata_a), .rdata_b_o(rdata_b),
        .we_i(rf_we), .wa_i(dst), .wdata_i(rf_wdata)
    );

    assign pc_plus4 = pc_q + 32'd4;
    assign pc_next  = is_jump ? {pc_q[31:28], ir_q[25:0], 2'b00} :
                      (is_branch && alu_y[0]) ? pc_plus4 + {imm[29:0], 2'b00} :
                      pc_plus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= ST_IDLE;
            pc_q       <= '0;
            req_sent_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: if (start_i) state_q <= ST_FETCH;
                ST_FETCH: begin
                    if (fetch_gnt_i) req_sent_q <= 1'b1;
                    if (fetch_rvalid_i) begin
                        req_sent_q <= 1'b0;
                        state_q    <= ST_EXEC;
                    end
                end
                ST_EXEC: begin
                    pc_q <= pc_next;
                    if (is_break) state_q <= ST_HALT;
                    else if (is_load || is_store) state_q <= ST_MEM;
                    else state_q <= ST_FETCH;
                end
                ST_MEM: begin
                    if (dmem_gnt_i && is_store) state_q <= ST_FETCH;   // stores need no reply
                    else if (dmem_gnt_i) req_sent_q <= 1'b1;
                    if (dmem_rvalid_i) begin
                        req_sent_q <= 1'b0;
                        state_q    <= ST_FETCH;
                    end
                end
                default: state_q <= ST_HALT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_rvalid_i) ir_q <= rdata_i;
        if (state_q == ST_EXEC) begin
            dmem_addr_q  <= alu_y;
            dmem_wdata_q <= rdata_b;
        end
    end

    assign fetch_req_o   = (state_q == ST_FETCH) && !req_sent_q;
    assign fetch_addr_o  = pc_q;
    assign dmem_req_o    = (state_q == ST_MEM) && !req_sent_q;
    assign dmem_we_o     = is_store;
    assign dmem_addr_o   = dmem_addr_q;
    assign dmem_wdata_o  = dmem_wdata_q;
    assign store_valid_o = dmem_req_o && dmem_we_o && dmem_gnt_i;
    assign store_addr_o  = dmem_addr_q;
    assign store_data_o  = dmem_wdata_q;
    assign halted_o      = (state_q == ST_HALT);

    a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
        halted_o |=> halted_o && !fetch_req_o && !dmem_req_o);

    // data accesses must be aligned and land inside the memory
    a_dmem_range: assert property (@(posedge clk) disable iff (rst)
        dmem_req_o |-> (dmem_addr_o[1:0] == 2'b00) && ((dmem_addr_o >> (MEM_AW + 2)) == '0));

endmodule

`default_nettype wire

/* rtl/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;     // data, instruction or byte address
    typedef logic [4:0]  reg_idx_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
        ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_EQ, ALU_NE
    } alu_op_e;

    typedef enum logic [2:0] {
        ST_IDLE, ST_FETCH, ST_EXEC, ST_MEM, ST_HALT
    } core_state_e;

    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_SLTI  = 6'h0a;
    localparam logic [5:0] OP_SLTIU = 6'h0b;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_XORI  = 6'h0e;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    localparam logic [5:0] FUNCT_SLL   = 6'h00;
    localparam logic [5:0] FUNCT_SRL   = 6'h02;
    localparam logic [5:0] FUNCT_SRA   = 6'h03;
    localparam logic [5:0] FUNCT_BREAK = 6'h0d;
    localparam logic [5:0] FUNCT_ADDU  = 6'h21;
    localparam logic [5:0] FUNCT_SUBU  = 6'h23;
    localparam logic [5:0] FUNCT_AND   = 6'h24;
    localparam logic [5:0] FUNCT_OR    = 6'h25;
    localparam logic [5:0] FUNCT_XOR   = 6'h26;
    localparam logic [5:0] FUNCT_NOR   = 6'h27;
    localparam logic [5:0] FUNCT_SLT   = 6'h2a;
    localparam logic [5:0] FUNCT_SLTU  = 6'h2b;

endpackage

`default_nettype wire

/* rtl/mips_soc.sv */
`default_nettype none

module mips_soc
    import mips_pkg::*;
#(
    parameter int MEM_AW = 10
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start_i,
    input  logic              load_we_i,
    input  logic [MEM_AW-1:0] load_addr_i,
    input  word_t             load_data_i,
    output logic              store_valid_o,
    output word_t             store_addr_o,
    output word_t             store_data_o,
    output logic              halted_o
);

    logic              fetch_req, fetch_gnt, fetch_rvalid;
    logic              dmem_req, dmem_we, dmem_gnt, dmem_rvalid;
    word_t             fetch_addr, dmem_addr, dmem_wdata;
    logic              mem_en, mem_we;
    logic [MEM_AW-1:0] mem_addr;
    word_t             mem_wdata, mem_rdata;

    mips_core #(.MEM_AW(MEM_AW)) u_core (
        .clk(clk), .rst(rst), .start_i(start_i),
        .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr),
        .fetch_gnt_i(fetch_gnt), .fetch_rvalid_i(fetch_rvalid),
        .dmem_req_o(dmem_req), .dmem_we_o(dmem_we), .dmem_addr_o(dmem_addr),
        .dmem_wdata_o(dmem_wdata), .dmem_gnt_i(dmem_gnt), .dmem_rvalid_i(dmem_rvalid),
        .rdata_i(mem_rdata),
        .store_valid_o(store_valid_o), .store_addr_o(store_addr_o),
        .store_data_o(store_data_o), .halted_o(halted_o)
    );

    mem_arbiter #(.MEM_AW(MEM_AW)) u_arb (
        .clk(clk), .rst(rst),
        .load_we_i(load_we_i), .load_addr_i(load_addr_i), .load_data_i(load_data_i),
        .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
        .dmem_req_i(dmem_req), .dmem_we_i(dmem_we), .dmem_addr_i(dmem_addr),
        .dmem_wdata_i(dmem_wdata),
        .fetch_gnt_o(fetch_gnt), .dmem_gnt_o(dmem_gnt),
        .fetch_rvalid_o(fetch_rvalid), .dmem_rvalid_o(dmem_rvalid),
        .mem_en_o(mem_en), .mem_we_o(mem_we), .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
    );

    unified_mem #(.MEM_AW(MEM_AW)) u_mem (
        .clk(clk), .en_i(mem_en), .we_i(mem_we), .addr_i(mem_addr),
        .wdata_i(mem_wdata), .rdata_o(mem_rdata)
    );

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`default_nettype none

module reg_file
    import mips_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  reg_idx_t ra_i,
    input  reg_idx_t rb_i,
    output word_t    rdata_a_o,
    output word_t    rdata_b_o,
    input  logic     we_i,
    input  reg_idx_t wa_i,
    input  word_t    wdata_i
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && wa_i != '0) begin   // r0 never written
            regs[wa_i] <= wdata_i;
        end
    end

    assign rdata_a_o = regs[ra_i];
    assign rdata_b_o = regs[rb_i];

    a_r0_zero: assert property (@(posedge clk) disable iff (rst)
        (ra_i == '0) |-> (rdata_a_o == '0));

endmodule

`default_nettype wire

/* rtl/unified_mem.sv */
`default_nettype none

module unified_mem
    import mips_pkg::*;
#(
    parameter int MEM_AW = 10
) (
    input  logic              clk,
    input  logic              en_i,
    input  logic              we_i,
    input  logic [MEM_AW-1:0] addr_i,
    input  word_t             wdata_i,
    output word_t             rdata_o
);

    word_t mem [2**MEM_AW];

    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];   // one cycle read
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module tb_top -f src.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$LOG"; then
    exit 0
fi
exit 1

/* src.f */
rtl/mips_pkg.sv
rtl/inst_decoder.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/mem_arbiter.sv
rtl/unified_mem.sv
rtl/mips_core.sv
rtl/mips_soc.sv
bench/tb_checker.sv
bench/tb_top.sv
